// ==== include/cfgreg_params.svh ====
`ifndef CFGREG_PARAMS_SVH
`define CFGREG_PARAMS_SVH

// Core and register widths.
`define XLEN        32
`define REG_ADDR_W  12
`define REG_DATA_W  32

// Register offsets within the 4 KB config page.
`define CFGREG_RSTN       12'h000
`define CFGREG_BOOTVEC    12'h004
`define CFGREG_DDROFFSET  12'h008
`define CFGREG_RSVREG0    12'h00C
`define CFGREG_RSVREG1    12'h010
`define CFGREG_VER        12'h018
`define CFGREG_VER_LO     (`CFGREG_VER + 12'h004)

// Version word. Upper half at CFGREG_VER, lower half at CFGREG_VER_LO.
`define RISCV_VER  64'h5256_3332_0001_0003

// Reset value of the DDR offset register.
`define DDR_OFFSET_RST  32'h2000_0000

// Core addresses in [base, base + size) are moved onto the DDR offset.
`define DDR_WIN_BASE  32'h8000_0000
`define DDR_WIN_SIZE  32'h4000_0000

// Core reset is held this many cycles after a release request.
`define RST_HOLD_CYCLES  8

`endif

// ==== source/cfgreg_pkg.sv ====
`include "cfgreg_params.svh"

package cfgreg_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_DATA_W-1:0] reg_data_t;
    typedef logic [`XLEN-1:0]       xlen_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        reg_addr_t paddr;
        reg_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        reg_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // One-cycle register access, issued in the APB setup phase.
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_acc_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } mem_req_t;

    typedef enum logic [1:0] {IN_RESET, HOLD, RUNNING} rst_state_t;

endpackage

// ==== source/apb_reg_port.sv ====
`timescale 1ns/100ps

module apb_reg_port import cfgreg_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output reg_acc_t  acc,
    input  reg_data_t rdata,
    input  logic      hit
);

    logic      setup;
    reg_data_t prdata_q;
    logic      pslverr_q;

    assign setup = apb_req.psel & ~apb_req.penable;  // First cycle of a transfer.

    // Strobes last the setup cycle only, so a write commits at its end.
    always_comb begin
        acc.wr    = setup & apb_req.pwrite;
        acc.rd    = setup & ~apb_req.pwrite;
        acc.addr  = apb_req.paddr;
        acc.wdata = apb_req.pwdata;
    end

    // Captured at the setup edge, valid through the access cycle.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (setup) begin
            prdata_q  <= rdata;  // Writes return zero.
            pslverr_q <= ~hit;
        end
    end

    always_comb begin
        apb_rsp.prdata  = prdata_q;
        apb_rsp.pready  = 1'b1;  // No wait states.
        apb_rsp.pslverr = pslverr_q;
    end

    a_penable_after_setup: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel)
    ) else $error("penable rose without a preceding setup cycle");

endmodule

// ==== source/cfgreg.sv ====
`timescale 1ns/100ps
`include "cfgreg_params.svh"

module cfgreg import cfgreg_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  reg_acc_t  acc,
    output reg_data_t rdata,
    output logic      hit,
    input  logic      core_rstn,
    output logic      pwron,
    output logic      srst_req,
    output xlen_t     core_bootvec,
    output reg_data_t ddr_offset
);

    localparam logic [63:0] VERSION = `RISCV_VER;

    logic      wr_rstn;
    logic      wr_bootvec;
    logic      wr_ddroffset;
    logic      wr_rsv0;
    logic      wr_rsv1;
    reg_data_t rsv_reg0;
    reg_data_t rsv_reg1;

    assign wr_rstn      = acc.wr && (acc.addr == `CFGREG_RSTN);
    assign wr_bootvec   = acc.wr && (acc.addr == `CFGREG_BOOTVEC);
    assign wr_ddroffset = acc.wr && (acc.addr == `CFGREG_DDROFFSET);
    assign wr_rsv0      = acc.wr && (acc.addr == `CFGREG_RSVREG0);
    assign wr_rsv1      = acc.wr && (acc.addr == `CFGREG_RSVREG1);

    // Bit 0 is the power-on level, bit 31 requests a soft reset.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pwron    <= 1'b0;
            srst_req <= 1'b0;
        end else begin
            if (wr_rstn) begin
                pwron <= acc.wdata[0];
            end
            srst_req <= wr_rstn & acc.wdata[31];  // Single-cycle pulse.
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            core_bootvec <= '0;
        end else if (wr_bootvec) begin
            core_bootvec <= xlen_t'(acc.wdata);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ddr_offset <= `DDR_OFFSET_RST;
        end else if (wr_ddroffset) begin
            ddr_offset <= acc.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsv_reg0 <= '0;
        end else if (wr_rsv0) begin
            rsv_reg0 <= acc.wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsv_reg1 <= '0;
        end else if (wr_rsv1) begin
            rsv_reg1 <= acc.wdata;
        end
    end

    // Read mux and address decode. Unmapped offsets read zero.
    always_comb begin
        rdata = '0;
        hit   = 1'b1;
        case (acc.addr)
            `CFGREG_RSTN:      rdata = {31'b0, core_rstn};  // Live reset status.
            `CFGREG_BOOTVEC:   rdata = reg_data_t'(core_bootvec);
            `CFGREG_DDROFFSET: rdata = ddr_offset;
            `CFGREG_RSVREG0:   rdata = rsv_reg0;
            `CFGREG_RSVREG1:   rdata = rsv_reg1;
            `CFGREG_VER:       rdata = VERSION[63:32];
            `CFGREG_VER_LO:    rdata = VERSION[31:0];
            default:           hit   = 1'b0;
        endcase
        if (!acc.rd) begin
            rdata = '0;  // Data only on a read strobe.
        end
    end

    a_single_access: assert property (
        @(posedge clk) disable iff (!rstn)
        !(acc.wr && acc.rd)
    ) else $error("read and write strobes active together");

endmodule

// ==== source/core_reset_ctrl.sv ====
`timescale 1ns/100ps
`include "cfgreg_params.svh"

module core_reset_ctrl import cfgreg_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic pwron,
    input  logic srst_req,
    output logic core_rstn
);

    localparam int HOLD_W = $clog2(`RST_HOLD_CYCLES);
    // The output register supplies the final hold cycle.
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`RST_HOLD_CYCLES - 2);

    rst_state_t        state;
    rst_state_t        state_nxt;
    logic [HOLD_W-1:0] hold_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            IN_RESET: begin
                if (pwron) begin
                    state_nxt = HOLD;
                end
            end
            HOLD: begin
                if (!pwron || srst_req) begin
                    state_nxt = IN_RESET;  // Restart the hold.
                end else if (hold_cnt == HOLD_LAST) begin
                    state_nxt = RUNNING;
                end
            end
            RUNNING: begin
                if (!pwron || srst_req) begin
                    state_nxt = IN_RESET;
                end
            end
            default: state_nxt = IN_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IN_RESET;
            hold_cnt  <= '0;
            core_rstn <= 1'b0;
        end else begin
            state     <= state_nxt;
            hold_cnt  <= (state == HOLD) ? hold_cnt + 1'b1 : '0;
            core_rstn <= (state == RUNNING);
        end
    end

    // Once power has been off for two samples the core must be in reset.
    a_rstn_follows_pwron: assert property (
        @(posedge clk) disable iff (!rstn)
        (!pwron && $past(!pwron)) |=> !core_rstn
    ) else $error("core_rstn high with pwron low");

endmodule

// ==== source/ddr_addr_remap.sv ====
`timescale 1ns/100ps
`include "cfgreg_params.svh"

module ddr_addr_remap import cfgreg_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  reg_data_t ddr_offset,
    input  mem_req_t  core_req,
    output mem_req_t  mem_req
);

    localparam xlen_t WIN_BASE = `DDR_WIN_BASE;
    localparam xlen_t WIN_END  = `DDR_WIN_BASE + `DDR_WIN_SIZE;

    logic  in_win;
    xlen_t addr_nxt;
    logic  valid_q;
    xlen_t addr_q;

    assign in_win = (core_req.addr >= WIN_BASE) && (core_req.addr < WIN_END);

    always_comb begin
        if (in_win) begin
            addr_nxt = core_req.addr - WIN_BASE + xlen_t'(ddr_offset);
        end else begin
            addr_nxt = core_req.addr;  // Pass through.
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= core_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (core_req.valid) begin
            addr_q <= addr_nxt;
        end
    end

    always_comb begin
        mem_req.valid = valid_q;
        mem_req.addr  = addr_q;
    end

endmodule

// ==== source/cfg_subsys_top.sv ====
`timescale 1ns/100ps

module cfg_subsys_top import cfgreg_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  mem_req_t core_req,
    output mem_req_t mem_req,
    output xlen_t    core_bootvec,
    output logic     core_rstn
);

    reg_acc_t  acc;
    reg_data_t rdata;
    logic      hit;
    logic      pwron;
    logic      srst_req;
    reg_data_t ddr_offset;

    apb_reg_port u_apb_reg_port (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .acc     (acc),
        .rdata   (rdata),
        .hit     (hit)
    );

    cfgreg u_cfgreg (
        .clk          (clk),
        .rstn         (rstn),
        .acc          (acc),
        .rdata        (rdata),
        .hit          (hit),
        .core_rstn    (core_rstn),
        .pwron        (pwron),
        .srst_req     (srst_req),
        .core_bootvec (core_bootvec),
        .ddr_offset   (ddr_offset)
    );

    core_reset_ctrl u_core_reset_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .pwron     (pwron),
        .srst_req  (srst_req),
        .core_rstn (core_rstn)
    );

    ddr_addr_remap u_ddr_addr_remap (
        .clk        (clk),
        .rstn       (rstn),
        .ddr_offset (ddr_offset),
        .core_req   (core_req),
        .mem_req    (mem_req)
    );

endmodule

// ==== tests/cfg_subsys_tb.sv ====
`timescale 1ns/100ps
`include "cfgreg_params.svh"

module cfg_subsys_tb import cfgreg_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int REMAP_COUNT  = 32;
    // Rough cycle budget of each test, summed for the watchdog.
    localparam int TEST_CYCLES  = 20 + 30 + 16 + 20 + 45 + (REMAP_COUNT + 10);
    localparam int MARGIN_CYCLES = 100;

    logic     clk;
    logic     rstn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    mem_req_t core_req;
    mem_req_t mem_req;
    xlen_t    core_bootvec;
    logic     core_rstn;

    int          errors;
    int          tests_run;
    logic [31:0] lcg_state;
    logic        last_slverr;
    reg_data_t   bootvec_m;
    reg_data_t   ddroff_m;
    reg_data_t   rsv0_m;
    reg_data_t   rsv1_m;

    cfg_subsys_top u_cfg_subsys_top (
        .clk          (clk),
        .rstn         (rstn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .core_req     (core_req),
        .mem_req      (mem_req),
        .core_bootvec (core_bootvec),
        .core_rstn    (core_rstn)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Window rule for core addresses.
    function automatic xlen_t remap_addr(input xlen_t addr, input reg_data_t offset);
        if (addr >= `DDR_WIN_BASE && addr < (`DDR_WIN_BASE + `DDR_WIN_SIZE)) begin
            return addr - `DDR_WIN_BASE + offset;
        end
        return addr;
    endfunction

    task check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task apb_write(input reg_addr_t addr, input reg_data_t data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        tick();  // Commit edge.
        apb_req.penable = 1'b1;
        check("pready", apb_rsp.pready, 1);
        last_slverr = apb_rsp.pslverr;
        tick();
        apb_req = '0;
    endtask

    task apb_read(input reg_addr_t addr, output reg_data_t data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        tick();
        apb_req.penable = 1'b1;
        check("pready", apb_rsp.pready, 1);
        data        = apb_rsp.prdata;
        last_slverr = apb_rsp.pslverr;
        tick();
        apb_req = '0;
    endtask

    task read_expect(input reg_addr_t addr, input string name, input reg_data_t exp,
                     input logic exp_err);
        reg_data_t data;
        apb_read(addr, data);
        check(name, data, exp);
        check({name, " pslverr"}, last_slverr, exp_err);
    endtask

    task report_test(input int num, input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - errs_at_start);
        end
    endtask

    task read_reset_values();
        int errs_at_start;
        errs_at_start = errors;
        check("prdata", apb_rsp.prdata, 0);
        check("pslverr", apb_rsp.pslverr, 0);
        check("mem_req.valid", mem_req.valid, 0);
        check("core_bootvec", core_bootvec, 0);
        check("core_rstn", core_rstn, 0);
        read_expect(`CFGREG_RSTN, "rstn", 32'h0, 1'b0);
        read_expect(`CFGREG_BOOTVEC, "bootvec", 32'h0, 1'b0);
        read_expect(`CFGREG_DDROFFSET, "ddroffset", `DDR_OFFSET_RST, 1'b0);
        read_expect(`CFGREG_RSVREG0, "rsvreg0", 32'h0, 1'b0);
        read_expect(`CFGREG_RSVREG1, "rsvreg1", 32'h0, 1'b0);
        read_expect(`CFGREG_VER, "ver_hi", `RISCV_VER >> 32, 1'b0);
        read_expect(`CFGREG_VER + 12'h004, "ver_lo", `RISCV_VER & 64'hFFFF_FFFF, 1'b0);
        report_test(1, "reset values", errs_at_start);
    endtask

    task write_readback();
        int errs_at_start;
        errs_at_start = errors;
        bootvec_m = lcg_next();
        ddroff_m  = lcg_next();
        rsv0_m    = lcg_next();
        rsv1_m    = lcg_next();
        apb_write(`CFGREG_BOOTVEC, bootvec_m);
        check("write bootvec pslverr", last_slverr, 0);
        apb_write(`CFGREG_DDROFFSET, ddroff_m);
        check("write ddroffset pslverr", last_slverr, 0);
        apb_write(`CFGREG_RSVREG0, rsv0_m);
        check("write rsvreg0 pslverr", last_slverr, 0);
        apb_write(`CFGREG_RSVREG1, rsv1_m);
        check("write rsvreg1 pslverr", last_slverr, 0);
        read_expect(`CFGREG_BOOTVEC, "bootvec", bootvec_m, 1'b0);
        read_expect(`CFGREG_DDROFFSET, "ddroffset", ddroff_m, 1'b0);
        read_expect(`CFGREG_RSVREG0, "rsvreg0", rsv0_m, 1'b0);
        read_expect(`CFGREG_RSVREG1, "rsvreg1", rsv1_m, 1'b0);
        check("core_bootvec", core_bootvec, bootvec_m);
        report_test(2, "register write and readback", errs_at_start);
    endtask

    task unmapped_access();
        int errs_at_start;
        errs_at_start = errors;
        apb_write(12'h020, lcg_next());
        check("write unmapped pslverr", last_slverr, 1);
        read_expect(12'h020, "unmapped", 32'h0, 1'b1);
        read_expect(`CFGREG_BOOTVEC, "bootvec", bootvec_m, 1'b0);
        read_expect(`CFGREG_DDROFFSET, "ddroffset", ddroff_m, 1'b0);
        read_expect(`CFGREG_RSVREG0, "rsvreg0", rsv0_m, 1'b0);
        read_expect(`CFGREG_RSVREG1, "rsvreg1", rsv1_m, 1'b0);
        report_test(3, "unmapped access", errs_at_start);
    endtask

    task power_on_sequence();
        int errs_at_start;
        errs_at_start = errors;
        apb_write(`CFGREG_RSTN, 32'h0000_0001);
        // One edge past the commit here.
        for (int n = 1; n <= `RST_HOLD_CYCLES; n++) begin
            check("core_rstn during hold", core_rstn, 0);
            tick();
        end
        check("core_rstn after hold", core_rstn, 1);
        read_expect(`CFGREG_RSTN, "rstn", 32'h1, 1'b0);
        report_test(4, "power-on sequence", errs_at_start);
    endtask

    task soft_reset_power_off();
        int errs_at_start;
        errs_at_start = errors;
        apb_write(`CFGREG_RSTN, 32'h8000_0001);
        check("core_rstn one edge after soft reset", core_rstn, 1);
        tick();
        for (int n = 1; n <= `RST_HOLD_CYCLES; n++) begin
            check("core_rstn during soft reset", core_rstn, 0);
            tick();
        end
        check("core_rstn after soft reset", core_rstn, 1);
        read_expect(`CFGREG_RSTN, "rstn", 32'h1, 1'b0);
        apb_write(`CFGREG_RSTN, 32'h0000_0000);
        check("core_rstn one edge after power-off", core_rstn, 1);
        repeat (2 * `RST_HOLD_CYCLES) begin
            tick();
            check("core_rstn after power-off", core_rstn, 0);
        end
        read_expect(`CFGREG_RSTN, "rstn", 32'h0, 1'b0);
        report_test(5, "soft reset and power-off", errs_at_start);
    endtask

    task address_remap();
        int    errs_at_start;
        xlen_t addr_list [REMAP_COUNT];
        errs_at_start = errors;
        ddroff_m = lcg_next() & 32'hFFFF_F000;
        apb_write(`CFGREG_DDROFFSET, ddroff_m);
        addr_list[0] = `DDR_WIN_BASE - 1;  // Window edges first.
        addr_list[1] = `DDR_WIN_BASE;
        addr_list[2] = `DDR_WIN_BASE + `DDR_WIN_SIZE - 1;
        addr_list[3] = `DDR_WIN_BASE + `DDR_WIN_SIZE;
        for (int i = 4; i < REMAP_COUNT; i++) begin
            if (i % 2 == 0) begin
                addr_list[i] = `DDR_WIN_BASE + (lcg_next() & (`DDR_WIN_SIZE - 1));
            end else begin
                addr_list[i] = lcg_next();
            end
        end
        core_req.valid = 1'b1;
        core_req.addr  = addr_list[0];
        for (int i = 0; i < REMAP_COUNT; i++) begin
            tick();
            check("mem_req.valid", mem_req.valid, 1);
            check("mem_req.addr", mem_req.addr, remap_addr(addr_list[i], ddroff_m));
            if (i < REMAP_COUNT - 1) begin
                core_req.addr = addr_list[i + 1];
            end else begin
                core_req = '0;
            end
        end
        tick();
        check("mem_req.valid after burst", mem_req.valid, 0);
        report_test(6, "address remap", errs_at_start);
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired at %0t with tests still running", $time);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        apb_req   = '0;
        core_req  = '0;
        errors    = 0;
        tests_run = 0;
        lcg_state = 32'd26;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        read_reset_values();
        write_readback();
        unmapped_access();
        power_on_sequence();
        soft_reset_power_off();
        address_remap();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
source/cfgreg_pkg.sv
source/apb_reg_port.sv
source/cfgreg.sv
source/core_reset_ctrl.sv
source/ddr_addr_remap.sv
source/cfg_subsys_top.sv
tests/cfg_subsys_tb.sv
